// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_cart_loader
RTL_TOP    := cart_loader
FILELIST   := files.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --top-module $(RTL_TOP)
SIM_FLAGS  := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/cart_loader.sv
// Cartridge image loader top level
// Header capture and decode, load FSM and the memory write queue

`timescale 1ns/1ps

module cart_loader
	import loader_pkg::*;
#(
	parameter int RESET_HOLD = 255
) (
	input  logic          clk,
	input  logic          reset,
	input  logic          downloading,
	input  file_kind_t    file_kind,
	input  logic          invert_mirroring,
	input  logic          in_valid,
	input  logic [7:0]    in_data,
	output logic          in_ready,
	output logic          mem_valid,
	output mem_write_t    mem_write,
	input  logic          mem_ready,
	output mapper_flags_t flags,
	output logic          done,
	output logic          error,
	output logic          hold_reset
);

	logic              byte_taken;
	logic              load_start;
	header_t           header;
	logic              header_full;
	image_kind_t       image_kind;
	logic [ADDR_W-1:0] prg_bytes;
	logic [ADDR_W-1:0] chr_bytes;
	mapper_flags_t     decoded_flags;
	logic              write_valid;
	mem_write_t        write_rec;
	logic              write_ready;

	header_capture u_capture (
		.clk(clk), .reset(reset), .load_start(load_start), .byte_taken(byte_taken),
		.in_data(in_data), .header(header), .header_full(header_full)
	);

	header_decode u_decode (
		.header(header), .file_kind(file_kind), .invert_mirroring(invert_mirroring),
		.image_kind(image_kind), .prg_bytes(prg_bytes), .chr_bytes(chr_bytes),
		.decoded_flags(decoded_flags)
	);

	load_control #(.RESET_HOLD(RESET_HOLD)) u_control (
		.clk(clk), .reset(reset), .downloading(downloading), .file_kind(file_kind),
		.in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
		.header_full(header_full), .image_kind(image_kind), .prg_bytes(prg_bytes),
		.chr_bytes(chr_bytes), .decoded_flags(decoded_flags), .byte_taken(byte_taken),
		.load_start(load_start), .write_valid(write_valid), .write_rec(write_rec),
		.write_ready(write_ready), .flags(flags), .done(done), .error(error),
		.hold_reset(hold_reset)
	);

	write_queue u_queue (
		.clk(clk), .reset(reset), .in_valid(write_valid), .in_rec(write_rec),
		.in_ready(write_ready), .out_valid(mem_valid), .out_rec(mem_write),
		.out_ready(mem_ready)
	);

endmodule

// File: design/header_capture.sv
// Header capture: stores the first header bytes of an image in arrival order
// and flags when the header array is complete

`timescale 1ns/1ps

module header_capture
	import loader_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    load_start,
	input  logic    byte_taken,
	input  logic    [7:0] in_data,
	output header_t header,
	output logic    header_full
);

	localparam int SEL_W = $clog2(HEADER_BYTES);

	logic [SEL_W:0] index; // One extra bit to count up to a full header

	assign header_full = (index == (SEL_W+1)'(HEADER_BYTES));

	always_ff @(posedge clk) begin
		if (reset) begin
			index <= '0;
		end else if (load_start) begin
			index <= '0; // New image starts from byte 0
		end else if (byte_taken && !header_full) begin
			index <= index + 1'b1;
		end
	end

	// Bytes past the header are ignored here
	always_ff @(posedge clk) begin
		if (byte_taken && !header_full) begin
			header[index[SEL_W-1:0]] <= in_data;
		end
	end

endmodule

// File: design/header_decode.sv
// Header decoder: image classification, mapper flags and PRG/CHR byte counts
// Purely combinational

`timescale 1ns/1ps

module header_decode
	import loader_pkg::*;
(
	input  header_t            header,
	input  file_kind_t         file_kind,
	input  logic               invert_mirroring,
	output image_kind_t        image_kind,
	output logic [ADDR_W-1:0]  prg_bytes,
	output logic [ADDR_W-1:0]  chr_bytes,
	output mapper_flags_t      decoded_flags
);

	logic nes_magic;
	logic fds_magic;
	logic has_trainer;
	logic is_nes20;
	logic is_dirty;

	// Smallest power of two page count that holds the given pages
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		if (pages <= 8'd1)       code = 3'd0;
		else if (pages <= 8'd2)  code = 3'd1;
		else if (pages <= 8'd4)  code = 3'd2;
		else if (pages <= 8'd8)  code = 3'd3;
		else if (pages <= 8'd16) code = 3'd4;
		else if (pages <= 8'd32) code = 3'd5;
		else if (pages <= 8'd64) code = 3'd6;
		else                     code = 3'd7;
		return code;
	endfunction

	assign nes_magic = (header[0] == 8'h4E) && (header[1] == 8'h45) &&
	                   (header[2] == 8'h53) && (header[3] == 8'h1A);
	assign fds_magic = (header[0] == 8'h46) && (header[1] == 8'h44) &&
	                   (header[2] == 8'h53) && (header[3] == 8'h1A);
	assign has_trainer = header[6][2]; // Trainers are not supported

	assign is_nes20 = (header[7][3:2] == 2'b10);
	// Old dumpers left junk in bytes 8 to 15
	assign is_dirty = !is_nes20 && (header[15:8] != '0);

	always_comb begin
		if (nes_magic && !has_trainer)
			image_kind = IMAGE_INES;
		else if (fds_magic || file_kind == FILE_FDS || file_kind == FILE_BIOS)
			image_kind = IMAGE_RAW;
		else
			image_kind = IMAGE_BAD;
	end

	assign prg_bytes = ADDR_W'(header[4]) * ADDR_W'(PRG_PAGE_BYTES);
	assign chr_bytes = ADDR_W'(header[5]) * ADDR_W'(CHR_PAGE_BYTES);

	always_comb begin
		decoded_flags.ext         = is_nes20 ? header[8] : 8'h00;
		decoded_flags.four_screen = header[6][3];
		decoded_flags.chr_ram     = (header[5] == 8'h00); // No CHR ROM pages
		decoded_flags.mirroring   = header[6][0] ^ invert_mirroring;
		decoded_flags.chr_size    = size_code(header[5]);
		decoded_flags.prg_size    = size_code(header[4]);
		decoded_flags.mapper      = {is_dirty ? 4'h0 : header[7][7:4], header[6][7:4]};
	end

endmodule

// File: design/load_control.sv
// Load FSM with the write address and remaining byte counters
// Done/error status, mapper flag latch and the console reset hold counter

`timescale 1ns/1ps

module load_control
	import loader_pkg::*;
#(
	parameter int RESET_HOLD = 255
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              downloading,
	input  file_kind_t        file_kind,
	input  logic              in_valid,
	output logic              in_ready,
	input  logic [7:0]        in_data,
	input  logic              header_full,
	input  image_kind_t       image_kind,
	input  logic [ADDR_W-1:0] prg_bytes,
	input  logic [ADDR_W-1:0] chr_bytes,
	input  mapper_flags_t     decoded_flags,
	output logic              byte_taken,
	output logic              load_start,
	output logic              write_valid,
	output mem_write_t        write_rec,
	input  logic              write_ready,
	output mapper_flags_t     flags,
	output logic              done,
	output logic              error,
	output logic              hold_reset
);

	localparam int HOLD_W = (RESET_HOLD > 1) ? $clog2(RESET_HOLD + 1) : 1;

	typedef enum logic [2:0] {
		S_HEADER, S_PRG, S_CHR, S_RAW, S_FINISHED, S_FAILED
	} state_t;

	state_t            state;
	logic              downloading_d;
	logic [ADDR_W-1:0] addr;
	logic [ADDR_W-1:0] remaining;
	logic [HOLD_W-1:0] hold_cnt;
	logic              init_hold;
	logic              writing;
	logic              dropping;

	function automatic logic [ADDR_W-1:0] base_addr(input file_kind_t kind);
		case (kind)
			FILE_BIOS: return BIOS_BASE;
			FILE_FDS:  return FDS_BASE;
			default:   return PRG_BASE;
		endcase
	endfunction

	assign load_start = downloading && !downloading_d;

	// States that store accepted bytes; PRG/CHR stall at zero to switch over
	always_comb begin
		case (state)
			S_HEADER:     writing = !header_full;
			S_PRG, S_CHR: writing = (remaining != '0);
			S_RAW:        writing = 1'b1;
			default:      writing = 1'b0;
		endcase
	end
	assign dropping = (state == S_FINISHED) && done; // Trailing bytes after a good load

	assign in_ready    = downloading && !load_start && ((writing && write_ready) || dropping);
	assign byte_taken  = in_valid && in_ready;
	assign write_valid = byte_taken && writing;
	assign write_rec   = '{addr: addr, data: in_data};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_FINISHED; // Idle until the first download, done stays low
			addr <= '0;
			remaining <= '0;
			done <= 1'b0;
			error <= 1'b0;
			flags <= '0;
		end else if (load_start) begin
			state <= S_HEADER;
			addr <= base_addr(file_kind);
			done <= 1'b0;
			error <= 1'b0;
		end else begin
			if (write_valid)
				addr <= addr + 1'b1;
			case (state)
				S_HEADER: begin
					if (header_full) begin
						case (image_kind)
							IMAGE_INES: begin
								state <= S_PRG;
								addr <= PRG_BASE; // Header bytes there get overwritten
								remaining <= prg_bytes;
							end
							IMAGE_RAW: state <= S_RAW;
							default: begin
								state <= S_FAILED;
								done <= 1'b1;
								error <= 1'b1;
							end
						endcase
					end else if (!downloading) begin
						state <= S_FAILED; // Image shorter than a header
						done <= 1'b1;
						error <= 1'b1;
					end
				end
				S_PRG, S_CHR: begin
					if (remaining == '0) begin
						if (state == S_PRG) begin
							state <= S_CHR;
							addr <= CHR_BASE;
							remaining <= chr_bytes;
						end else begin
							state <= S_FINISHED;
							done <= 1'b1;
							flags <= decoded_flags;
						end
					end else if (byte_taken) begin
						remaining <= remaining - 1'b1;
					end else if (!downloading) begin
						state <= S_FAILED; // Transfer ended early
						done <= 1'b1;
						error <= 1'b1;
					end
				end
				S_RAW: begin
					if (!downloading) begin
						state <= S_FINISHED;
						done <= 1'b1;
						flags <= RAW_FLAGS;
					end
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			downloading_d <= 1'b0;
			hold_cnt <= '0;
			init_hold <= 1'b1; // Console waits for a first image
		end else begin
			downloading_d <= downloading;
			if (downloading) begin
				hold_cnt <= HOLD_W'(RESET_HOLD);
				init_hold <= 1'b0;
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
		end
	end

	assign hold_reset = downloading || error || init_hold || (hold_cnt != '0);

	// Bytes arrive only during a download and are never stored after done
	a_byte_in_download: assert property (@(posedge clk) disable iff (reset)
		byte_taken |-> downloading && !(done && writing));

endmodule

// File: design/loader_pkg.sv
// Shared widths, cartridge memory bases and page sizes for the image loader
// File and image kinds, the memory write record and the mapper flag record
// Fixed mapper flags used for disk and BIOS images

package loader_pkg;

	localparam int ADDR_W       = 22;
	localparam int HEADER_BYTES = 16;

	// Start addresses in cartridge memory
	localparam logic [ADDR_W-1:0] PRG_BASE  = 22'h000000;
	localparam logic [ADDR_W-1:0] CHR_BASE  = 22'h200000;
	localparam logic [ADDR_W-1:0] FDS_BASE  = 22'h010000;
	localparam logic [ADDR_W-1:0] BIOS_BASE = 22'h000000;

	localparam int PRG_PAGE_BYTES = 16384;
	localparam int CHR_PAGE_BYTES = 8192;

	// Kind of file announced by the host
	typedef enum logic [1:0] {
		FILE_NES  = 2'd0,
		FILE_BIOS = 2'd1,
		FILE_FDS  = 2'd2
	} file_kind_t;

	// Kind of image found in the header
	typedef enum logic [1:0] {
		IMAGE_INES = 2'd0,
		IMAGE_RAW  = 2'd1,
		IMAGE_BAD  = 2'd2
	} image_kind_t;

	typedef logic [HEADER_BYTES-1:0][7:0] header_t; // Byte i is header[i]

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0]        data;
	} mem_write_t;

	typedef struct packed {
		logic [7:0] ext;         // NES 2.0 extension byte
		logic       four_screen;
		logic       chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;    // log2 of CHR size in 8 KB units
		logic [2:0] prg_size;    // log2 of PRG size in 16 KB units
		logic [7:0] mapper;
	} mapper_flags_t;

	// Same result as a header with bytes 4 to 7 set to FF 00 40 10
	localparam mapper_flags_t RAW_FLAGS = '{
		ext:         8'h00,
		four_screen: 1'b0,
		chr_ram:     1'b1,
		mirroring:   1'b0,
		chr_size:    3'd0,
		prg_size:    3'd7,
		mapper:      8'd20
	};

endpackage

// File: design/write_queue.sv
// Two-entry FIFO for memory write records with valid/ready on both sides

`timescale 1ns/1ps

module write_queue
	import loader_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       in_valid,
	input  mem_write_t in_rec,
	output logic       in_ready,
	output logic       out_valid,
	output mem_write_t out_rec,
	input  logic       out_ready
);

	mem_write_t entry [2];
	logic       wr_ptr;
	logic       rd_ptr;
	logic [1:0] count;
	logic       push;
	logic       pop;

	assign in_ready  = (count != 2'd2); // Not full
	assign out_valid = (count != 2'd0);
	assign out_rec   = entry[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count <= 2'd0;
		end else begin
			if (push)
				wr_ptr <= !wr_ptr;
			if (pop)
				rd_ptr <= !rd_ptr;
			count <= count + {1'b0, push} - {1'b0, pop};
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			entry[wr_ptr] <= in_rec;
	end

	a_out_stable: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_rec));

endmodule

// File: files.f
+incdir+tb
design/loader_pkg.sv
design/header_capture.sv
design/header_decode.sv
design/load_control.sv
design/write_queue.sv
design/cart_loader.sv
tb/tb_cart_loader.sv

// File: tb/tb_tasks.svh
// Testbench tasks: cycle stepping, timeouts and compare tasks
// Image builders, byte stream drive and the directed tests

task automatic next_cycle();
	@(posedge clk);
	#1;
endtask

task automatic report_timeout(input string what);
	$display("Timeout at %0d ns: gave up waiting for %s", $time, what);
	aborted = 1'b1;
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAIL at %0d ns: %s is %b, expected %b", $time, what, got, exp);
	end
endtask

task automatic check_count(input int got, input int exp, input string what);
	checks++;
	if (got != exp) begin
		errors++;
		$display("FAIL at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
	end
endtask

task automatic check_flags(input mapper_flags_t got, input mapper_flags_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("FAIL at %0d ns: flags are %h, expected %h", $time, got, exp);
	end
endtask

task automatic check_byte(input logic [ADDR_W-1:0] addr, input logic [7:0] exp);
	checks++;
	if (!mem.exists(addr)) begin
		errors++;
		$display("FAIL at %0d ns: nothing written at address %h", $time, addr);
	end else if (mem[addr] !== exp) begin
		errors++;
		$display("FAIL at %0d ns: address %h holds %h, expected %h", $time, addr,
			mem[addr], exp);
	end
endtask

function automatic mapper_flags_t make_flags(input logic [7:0] mapper,
	input logic [2:0] prg_size, input logic [2:0] chr_size, input logic mirroring,
	input logic chr_ram, input logic four_screen, input logic [7:0] ext);
	mapper_flags_t f;
	f.ext = ext;
	f.four_screen = four_screen;
	f.chr_ram = chr_ram;
	f.mirroring = mirroring;
	f.chr_size = chr_size;
	f.prg_size = prg_size;
	f.mapper = mapper;
	return f;
endfunction

function automatic header_t nes_header(input logic [7:0] prg_pages, input logic [7:0] chr_pages,
	input logic [7:0] flags6, input logic [7:0] flags7, input logic [63:0] tail);
	header_t h;
	h[3:0] = 32'h1A53454E; // "NES" then EOF
	h[4] = prg_pages;
	h[5] = chr_pages;
	h[6] = flags6;
	h[7] = flags7;
	h[15:8] = tail;        // Byte 8 in the low bits
	return h;
endfunction

function automatic logic [7:0] random_byte();
	logic [7:0] b;
	b = '0;
	for (int i = 0; i < 8; i++) begin
		data_lfsr = lfsr_next(data_lfsr);
		b = {b[6:0], data_lfsr[0]};
	end
	return b;
endfunction

function automatic void build_image(input header_t hdr, input int body_bytes);
	image.delete();
	for (int i = 0; i < HEADER_BYTES; i++)
		image.push_back(hdr[i]);
	for (int i = 0; i < body_bytes; i++)
		image.push_back(random_byte());
endfunction

task automatic start_download(input file_kind_t kind, input logic invert);
	mem.delete();
	file_kind = kind;
	invert_mirroring = invert;
	downloading = 1'b1;
	next_cycle();
endtask

task automatic send_bytes(input int first, input int count);
	int   waited;
	logic taken;
	for (int i = first; i < first + count; i++) begin
		in_valid = 1'b1;
		in_data = image[i];
		waited = 0;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = in_ready;
			next_cycle();
			waited++;
			if (!taken && waited >= STEP_TIMEOUT) begin
				report_timeout("a byte to be accepted");
				in_valid = 1'b0;
				return;
			end
		end
	end
	in_valid = 1'b0;
endtask

// Waits for done, or for the write queue to run empty
task automatic wait_until(input logic for_done);
	int    waited;
	string what;
	waited = 0;
	if (for_done)
		what = "done";
	else
		what = "the write queue to drain";
	@(negedge clk);
	while (for_done ? !done : mem_valid) begin
		waited++;
		if (waited > STEP_TIMEOUT) begin
			report_timeout(what);
			return;
		end
		@(negedge clk);
	end
	next_cycle();
endtask

// iNES loads finish before downloading falls, raw images only after it
task automatic run_load(input file_kind_t kind, input logic invert, input logic done_first);
	start_download(kind, invert);
	send_bytes(0, image.size());
	if (done_first && !aborted)
		wait_until(1'b1);
	if (!aborted) begin
		downloading = 1'b0;
		next_cycle();
	end
	if (!done_first && !aborted)
		wait_until(1'b1);
	if (!aborted)
		wait_until(1'b0);
endtask

task automatic check_stream(input int first, input int count, input logic [ADDR_W-1:0] base);
	for (int i = 0; i < count; i++)
		check_byte(base + ADDR_W'(i), image[first + i]);
endtask

task automatic check_status(input logic exp_error);
	check_bit(done, 1'b1, "done");
	check_bit(error, exp_error, "error");
endtask

task automatic finish_test(input string name, input int errors_before);
	tests++;
	if (aborted)
		$display("Test %s stopped by a timeout", name);
	else
		$display("Test %s finished with %0d errors", name, errors - errors_before);
endtask

task automatic check_after_reset();
	check_bit(in_ready, 1'b0, "in_ready after reset");
	check_bit(mem_valid, 1'b0, "mem_valid after reset");
	check_bit(done, 1'b0, "done after reset");
	check_bit(error, 1'b0, "error after reset");
	check_bit(hold_reset, 1'b1, "hold_reset after reset");
endtask

task automatic ines_image_load();
	int errs;
	errs = errors;
	// Mapper 0x43, vertical mirroring, one PRG and one CHR page
	build_image(nes_header(8'd1, 8'd1, 8'h31, 8'h40, 64'h0), PRG_PAGE_BYTES + CHR_PAGE_BYTES);
	backpressure = 1'b1;
	run_load(FILE_NES, 1'b0, 1'b1);
	backpressure = 1'b0;
	if (!aborted) begin
		check_stream(HEADER_BYTES, PRG_PAGE_BYTES, PRG_BASE);
		check_stream(HEADER_BYTES + PRG_PAGE_BYTES, CHR_PAGE_BYTES, CHR_BASE);
		check_flags(flags, make_flags(8'h43, 3'd0, 3'd0, 1'b1, 1'b0, 1'b0, 8'h00));
		check_status(1'b0);
	end
	finish_test("ines_load", errs);
endtask

task automatic nes20_chr_ram_load();
	int errs;
	errs = errors;
	// NES 2.0 marker in byte 7, extension byte 0x35, no CHR pages
	build_image(nes_header(8'd1, 8'd0, 8'h21, 8'h18, 64'h00000000_00070035), PRG_PAGE_BYTES);
	run_load(FILE_NES, 1'b1, 1'b1);
	if (!aborted) begin
		check_stream(HEADER_BYTES, PRG_PAGE_BYTES, PRG_BASE);
		check_flags(flags, make_flags(8'h12, 3'd0, 3'd0, 1'b0, 1'b1, 1'b0, 8'h35));
		check_status(1'b0);
	end
	finish_test("nes20_chr_ram", errs);
endtask

task automatic dirty_header_load();
	int errs;
	errs = errors;
	// Junk text in bytes 8 to 15 drops the high mapper nibble 7
	build_image(nes_header(8'd2, 8'd1, 8'h59, 8'h70, 64'h65647544_6B736944),
		2 * PRG_PAGE_BYTES + CHR_PAGE_BYTES);
	run_load(FILE_NES, 1'b0, 1'b1);
	if (!aborted) begin
		check_stream(HEADER_BYTES, 2 * PRG_PAGE_BYTES, PRG_BASE);
		check_stream(HEADER_BYTES + 2 * PRG_PAGE_BYTES, CHR_PAGE_BYTES, CHR_BASE);
		check_flags(flags, make_flags(8'h05, 3'd1, 3'd0, 1'b1, 1'b0, 1'b1, 8'h00));
		check_status(1'b0);
	end
	finish_test("dirty_header", errs);
endtask

task automatic bad_header_reject();
	int      errs;
	header_t bad;
	errs = errors;
	bad = '0;
	bad[3:0] = 32'h46494E55; // UNIF magic is not supported
	build_image(bad, 0);
	start_download(FILE_NES, 1'b0);
	send_bytes(0, HEADER_BYTES);
	if (!aborted)
		wait_until(1'b1);
	if (!aborted) begin
		check_status(1'b1);
		in_valid = 1'b1;
		in_data = 8'hA5;
		repeat (8) begin
			@(negedge clk);
			check_bit(in_ready, 1'b0, "in_ready after a bad header");
			next_cycle();
		end
		in_valid = 1'b0;
		downloading = 1'b0;
		repeat (RESET_HOLD + 4) next_cycle();
		check_bit(hold_reset, 1'b1, "hold_reset after a bad header");
	end
	finish_test("bad_header", errs);
endtask

task automatic disk_image_load();
	int      errs;
	header_t hdr;
	errs = errors;
	hdr = '0;
	hdr[3:0] = 32'h1A534446; // "FDS" then EOF
	hdr[4] = 8'd1;
	build_image(hdr, 2000);
	backpressure = 1'b1;
	run_load(FILE_FDS, 1'b0, 1'b0);
	backpressure = 1'b0;
	if (!aborted) begin
		check_stream(0, image.size(), FDS_BASE);
		check_flags(flags, make_flags(8'd20, 3'd7, 3'd0, 1'b0, 1'b1, 1'b0, 8'h00));
		check_status(1'b0);
	end
	finish_test("disk_image", errs);
endtask

task automatic reset_hold_timing();
	int errs;
	int high_cycles;
	errs = errors;
	build_image(nes_header(8'd1, 8'd0, 8'h00, 8'h00, 64'h0), PRG_PAGE_BYTES);
	start_download(FILE_NES, 1'b0);
	send_bytes(0, image.size());
	if (!aborted)
		wait_until(1'b1);
	if (!aborted) begin
		downloading = 1'b0;
		high_cycles = 0;
		@(negedge clk);
		while (hold_reset && high_cycles < 4 * RESET_HOLD) begin
			high_cycles++;
			@(negedge clk);
		end
		check_count(high_cycles, RESET_HOLD, "cycles of hold_reset after the load");
		check_bit(hold_reset, 1'b0, "hold_reset after the hold time");
		next_cycle();
	end
	finish_test("reset_hold", errs);
endtask

// File: tb/tb_cart_loader.sv
// Testbench for the cartridge image loader
// Clock, reset, DUT, memory model with random back-pressure and the test sequence

`timescale 1ns/1ps

module tb_cart_loader
	import loader_pkg::*;
();

	localparam int          RESET_HOLD   = 16;
	localparam int          STEP_TIMEOUT = 1000; // Cycles allowed for any single wait
	localparam logic [15:0] LFSR_SEED    = 16'd29209;

	logic          clk = 1'b0;
	logic          reset;
	logic          downloading;
	file_kind_t    file_kind;
	logic          invert_mirroring;
	logic          in_valid;
	logic [7:0]    in_data;
	logic          in_ready;
	logic          mem_valid;
	mem_write_t    mem_write;
	logic          mem_ready = 1'b1;
	mapper_flags_t flags;
	logic          done;
	logic          error;
	logic          hold_reset;

	logic [7:0]  mem [logic [ADDR_W-1:0]]; // Cartridge memory model
	logic [7:0]  image [$];                // Image bytes in send order
	logic [15:0] data_lfsr    = LFSR_SEED;
	logic [15:0] ready_lfsr   = LFSR_SEED;
	logic        backpressure = 1'b0;
	logic        aborted      = 1'b0;
	int          errors       = 0;
	int          checks       = 0;
	int          tests        = 0;

	always #4 clk = ~clk;

	cart_loader #(.RESET_HOLD(RESET_HOLD)) UUT (
		.clk(clk), .reset(reset), .downloading(downloading), .file_kind(file_kind),
		.invert_mirroring(invert_mirroring), .in_valid(in_valid), .in_data(in_data),
		.in_ready(in_ready), .mem_valid(mem_valid), .mem_write(mem_write),
		.mem_ready(mem_ready), .flags(flags), .done(done), .error(error),
		.hold_reset(hold_reset)
	);

	// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// Memory side stalls about half the time when back-pressure is on
	always @(posedge clk) begin
		#1;
		if (backpressure) begin
			ready_lfsr = lfsr_next(ready_lfsr);
			mem_ready = ready_lfsr[0];
		end else begin
			mem_ready = 1'b1;
		end
	end

	// Inputs only move just after the rising edge, so mid-cycle values match the handshake
	always @(negedge clk) begin
		if (mem_valid && mem_ready)
			mem[mem_write.addr] = mem_write.data;
	end

	`include "tb_tasks.svh"

	initial begin
		reset = 1'b1;
		downloading = 1'b0;
		file_kind = FILE_NES;
		invert_mirroring = 1'b0;
		in_valid = 1'b0;
		in_data = 8'h00;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		check_after_reset();
		if (!aborted)
			ines_image_load();
		if (!aborted)
			nes20_chr_ram_load();
		if (!aborted)
			dirty_header_load();
		if (!aborted)
			bad_header_reject();
		if (!aborted)
			disk_image_load();
		if (!aborted)
			reset_hold_timing();
		$display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0 && !aborted) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
